/* src/scaler_cfg_pkg.sv */
////////////////////
// Video config shared definitions
// Widths, host command codes, reset timing and the output window type
////////////////////
`default_nettype none

package scaler_cfg_pkg;

	////////////////////
	// Widths
	////////////////////
	localparam int unsigned IO_W  = 16;
	localparam int unsigned DIM_W = 12;
	// Top bit flags a literal pixel size
	localparam int unsigned AR_W  = 13;
	localparam int unsigned CMD_W = 8;
	localparam int unsigned IDX_W = 8;

	// Division steps, one per product bit
	localparam int unsigned MD_ITER = 2 * DIM_W;

	typedef logic [DIM_W-1:0] dim_t;
	typedef logic [AR_W-1:0]  ar_t;

	////////////////////
	// Host commands
	////////////////////
	localparam logic [CMD_W-1:0] CMD_TIMING    = 8'h20;
	localparam logic [CMD_W-1:0] CMD_VSET      = 8'h27;
	localparam logic [CMD_W-1:0] CMD_HSET_FREE = 8'h37;
	localparam logic [CMD_W-1:0] CMD_AR_PRESET = 8'h3A;

	// 1920x1080 until the host says otherwise
	localparam dim_t DEF_WIDTH  = 12'd1920;
	localparam dim_t DEF_HEIGHT = 12'd1080;

	// Centred output window, inclusive bounds
	typedef struct packed {
		dim_t hmin;
		dim_t hmax;
		dim_t vmin;
		dim_t vmax;
	} win_t;

endpackage

`default_nettype wire

/* src/cmd_bus_if.sv */
////////////////////
// Decoded host word bus
// One valid pulse per accepted word, flagged as command or indexed data
////////////////////
`default_nettype none
`timescale 1ns/1ns

interface cmd_bus_if;

	logic                               word_valid;
	logic                               is_cmd;
	// Data word position within the open command
	logic [scaler_cfg_pkg::IDX_W-1:0]   index;
	logic [scaler_cfg_pkg::IO_W-1:0]    data;

	modport link_mp (output word_valid, output is_cmd, output index, output data);
	modport regs_mp (input word_valid, input is_cmd, input index, input data);

endinterface

`default_nettype wire

/* src/hps_cmd_link.sv */
////////////////////
// Host command link
// Synchronises select, strobe and data, acks each word
// and frames command and data words
////////////////////
`default_nettype none
`timescale 1ns/1ns

module hps_cmd_link (
	input  logic                              clk_sys,
	input  logic                              resetd,
	input  logic                              i_io_en,
	input  logic                              i_io_clk,
	input  logic [scaler_cfg_pkg::IO_W-1:0]   i_io_din,
	output logic                              o_io_ack,
	cmd_bus_if.link_mp                        cmd
);

	logic                              clk_s1, clk_s2;
	logic                              rack;
	logic                              en_s1, en_s2;
	logic [scaler_cfg_pkg::IO_W-1:0]   din_s1, din_s2;
	logic                              strobe;
	logic                              has_cmd;
	logic [scaler_cfg_pkg::IDX_W-1:0]  idx_cnt;

	// Rising edge of the synchronised word clock
	assign strobe = clk_s2 & ~rack;

	// Ack trails the host clock by four cycles
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			clk_s1   <= 1'b0;
			clk_s2   <= 1'b0;
			rack     <= 1'b0;
			o_io_ack <= 1'b0;
			en_s1    <= 1'b0;
			en_s2    <= 1'b0;
		end else begin
			clk_s1   <= i_io_clk;
			clk_s2   <= clk_s1;
			rack     <= clk_s2;
			o_io_ack <= rack;
			en_s1    <= i_io_en;
			en_s2    <= en_s1;
		end
	end

	// Host holds data stable through the whole handshake
	always_ff @(posedge clk_sys) begin
		din_s1 <= i_io_din;
		din_s2 <= din_s1;
		if (strobe)
			cmd.data <= din_s2;
	end

	////////////////////
	// Word framing
	////////////////////
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			has_cmd        <= 1'b0;
			idx_cnt        <= '0;
			cmd.word_valid <= 1'b0;
			cmd.is_cmd     <= 1'b0;
			cmd.index      <= '0;
		end else begin
			cmd.word_valid <= 1'b0;
			if (!en_s2) begin
				// Deselect closes the command
				has_cmd <= 1'b0;
			end else if (strobe) begin
				cmd.word_valid <= 1'b1;
				cmd.is_cmd     <= ~has_cmd;
				cmd.index      <= has_cmd ? idx_cnt : '0;
				if (!has_cmd) begin
					has_cmd <= 1'b1;
					idx_cnt <= '0;
				end else begin
					idx_cnt <= idx_cnt + 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* src/video_cfg_regs.sv */
////////////////////
// Video config registers
// Decodes host commands into timing, limits and aspect presets
////////////////////
`default_nettype none
`timescale 1ns/1ns

module video_cfg_regs (
	input  logic                  clk_sys,
	input  logic                  resetd,
	cmd_bus_if.regs_mp            cmd,
	output scaler_cfg_pkg::dim_t  o_width,
	output scaler_cfg_pkg::dim_t  o_height,
	output scaler_cfg_pkg::dim_t  o_hset,
	output scaler_cfg_pkg::dim_t  o_vset,
	output logic                  o_freescale,
	output scaler_cfg_pkg::ar_t   o_arc1x,
	output scaler_cfg_pkg::ar_t   o_arc1y,
	output scaler_cfg_pkg::ar_t   o_arc2x,
	output scaler_cfg_pkg::ar_t   o_arc2y
);

	logic [scaler_cfg_pkg::CMD_W-1:0] cur_cmd;
	scaler_cfg_pkg::dim_t             din_dim;
	scaler_cfg_pkg::ar_t              din_ar;

	// Low bits of the data word as a size or aspect value
	assign din_dim = cmd.data[scaler_cfg_pkg::DIM_W-1:0];
	assign din_ar  = cmd.data[scaler_cfg_pkg::AR_W-1:0];

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			cur_cmd     <= '0;
			o_width     <= scaler_cfg_pkg::DEF_WIDTH;
			o_height    <= scaler_cfg_pkg::DEF_HEIGHT;
			o_hset      <= '0;
			o_vset      <= '0;
			o_freescale <= 1'b0;
			o_arc1x     <= '0;
			o_arc1y     <= '0;
			o_arc2x     <= '0;
			o_arc2y     <= '0;
		end else if (cmd.word_valid) begin
			if (cmd.is_cmd) begin
				cur_cmd <= cmd.data[scaler_cfg_pkg::CMD_W-1:0];
			end else begin
				case (cur_cmd)
					////////////////////
					// Video timing
					////////////////////
					scaler_cfg_pkg::CMD_TIMING: begin
						// Porches and sync widths pass through unused
						if (cmd.index == 0)
							o_width <= din_dim;
						if (cmd.index == 4)
							o_height <= din_dim;
					end

					scaler_cfg_pkg::CMD_VSET: begin
						o_vset <= din_dim;
					end

					// Flag in bit 15, limit in the low bits
					scaler_cfg_pkg::CMD_HSET_FREE: begin
						o_freescale <= cmd.data[scaler_cfg_pkg::IO_W-1];
						o_hset      <= din_dim;
					end

					////////////////////
					// Aspect presets
					////////////////////
					scaler_cfg_pkg::CMD_AR_PRESET: begin
						case (cmd.index)
							0: o_arc1x <= din_ar;
							1: o_arc1y <= din_ar;
							2: o_arc2x <= din_ar;
							3: o_arc2y <= din_ar;
							default: ;
						endcase
					end

					default: ;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

/* src/seq_muldiv.sv */
////////////////////
// Sequential multiply then divide
// Full product, restoring division one bit per cycle
////////////////////
`default_nettype none
`timescale 1ns/1ns

module seq_muldiv (
	input  logic                  clk_sys,
	input  logic                  resetd,
	input  logic                  i_start,
	input  scaler_cfg_pkg::dim_t  i_mul1,
	input  scaler_cfg_pkg::dim_t  i_mul2,
	input  scaler_cfg_pkg::dim_t  i_div,
	output logic                  o_busy,
	output scaler_cfg_pkg::dim_t  o_result
);

	logic [scaler_cfg_pkg::MD_ITER-1:0]          product;
	logic [scaler_cfg_pkg::MD_ITER-1:0]          quo;
	scaler_cfg_pkg::dim_t                        rem;
	scaler_cfg_pkg::dim_t                        div_r;
	logic [scaler_cfg_pkg::DIM_W:0]              trial;
	logic [$clog2(scaler_cfg_pkg::MD_ITER)-1:0]  step;

	assign product = {{scaler_cfg_pkg::DIM_W{1'b0}}, i_mul1}
		* {{scaler_cfg_pkg::DIM_W{1'b0}}, i_mul2};

	// Remainder with next dividend bit shifted in
	assign trial = {rem, quo[scaler_cfg_pkg::MD_ITER-1]};

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			o_busy <= 1'b0;
			step   <= '0;
		end else if (i_start) begin
			o_busy <= 1'b1;
			step   <= $bits(step)'(scaler_cfg_pkg::MD_ITER - 1);
		end else if (o_busy) begin
			step <= step - 1'b1;
			if (step == '0)
				o_busy <= 1'b0;
		end
	end

	// Quotient bits replace dividend bits as they shift out
	always_ff @(posedge clk_sys) begin
		if (i_start) begin
			quo   <= product;
			rem   <= '0;
			div_r <= i_div;
		end else if (o_busy) begin
			if (trial >= {1'b0, div_r}) begin
				rem <= scaler_cfg_pkg::dim_t'(trial - {1'b0, div_r});
				quo <= {quo[scaler_cfg_pkg::MD_ITER-2:0], 1'b1};
			end else begin
				rem <= trial[scaler_cfg_pkg::DIM_W-1:0];
				quo <= {quo[scaler_cfg_pkg::MD_ITER-2:0], 1'b0};
			end
		end
	end

	assign o_result = quo[scaler_cfg_pkg::DIM_W-1:0];

endmodule

`default_nettype wire

/* src/ar_window_calc.sv */
////////////////////
// Aspect ratio window
// Fits the aspect into the display size and centres the result
////////////////////
`default_nettype none
`timescale 1ns/1ns

module ar_window_calc (
	input  logic                  clk_sys,
	input  logic                  resetd,
	input  scaler_cfg_pkg::dim_t  i_width,
	input  scaler_cfg_pkg::dim_t  i_height,
	input  scaler_cfg_pkg::dim_t  i_hset,
	input  scaler_cfg_pkg::dim_t  i_vset,
	input  logic                  i_freescale,
	input  scaler_cfg_pkg::ar_t   i_arx,
	input  scaler_cfg_pkg::ar_t   i_ary,
	input  scaler_cfg_pkg::ar_t   i_arc1x,
	input  scaler_cfg_pkg::ar_t   i_arc1y,
	input  scaler_cfg_pkg::ar_t   i_arc2x,
	input  scaler_cfg_pkg::ar_t   i_arc2y,
	output scaler_cfg_pkg::win_t  o_win
);

	typedef enum logic [2:0] {
		ST_DECIDE,
		ST_MUL_W,
		ST_WAIT_W,
		ST_MUL_H,
		ST_WAIT_H,
		ST_CLAMP,
		ST_CENTER
	} state_t;

	state_t                state;
	scaler_cfg_pkg::dim_t  disp_w, disp_h;
	scaler_cfg_pkg::dim_t  ax, ay;
	logic                  literal;
	scaler_cfg_pkg::dim_t  wcalc, hcalc;
	scaler_cfg_pkg::dim_t  vid_w, vid_h;
	scaler_cfg_pkg::dim_t  hoff, voff;
	logic                  md_start, md_busy;
	scaler_cfg_pkg::dim_t  md_mul1, md_mul2, md_div, md_res;

	seq_muldiv i_muldiv (
		.clk_sys  (clk_sys),
		.resetd   (resetd),
		.i_start  (md_start),
		.i_mul1   (md_mul1),
		.i_mul2   (md_mul2),
		.i_div    (md_div),
		.o_busy   (md_busy),
		.o_result (md_res)
	);

	////////////////////
	// Display size and aspect source
	////////////////////
	always_ff @(posedge clk_sys) begin
		disp_w <= (i_hset != '0 && i_hset < i_width) ? i_hset : i_width;
		disp_h <= (i_vset != '0 && i_vset < i_height) ? i_vset : i_height;

		if (i_ary == '0) begin
			// ARX picks a preset
			if (i_arx == scaler_cfg_pkg::ar_t'(1)) begin
				ax      <= i_arc1x[scaler_cfg_pkg::DIM_W-1:0];
				ay      <= i_arc1y[scaler_cfg_pkg::DIM_W-1:0];
				literal <= i_arc1x[scaler_cfg_pkg::AR_W-1] | i_arc1y[scaler_cfg_pkg::AR_W-1];
			end else if (i_arx == scaler_cfg_pkg::ar_t'(2)) begin
				ax      <= i_arc2x[scaler_cfg_pkg::DIM_W-1:0];
				ay      <= i_arc2y[scaler_cfg_pkg::DIM_W-1:0];
				literal <= i_arc2x[scaler_cfg_pkg::AR_W-1] | i_arc2y[scaler_cfg_pkg::AR_W-1];
			end else begin
				ax      <= '0;
				ay      <= '0;
				literal <= 1'b0;
			end
		end else begin
			ax      <= i_arx[scaler_cfg_pkg::DIM_W-1:0];
			ay      <= i_ary[scaler_cfg_pkg::DIM_W-1:0];
			literal <= i_arx[scaler_cfg_pkg::AR_W-1] | i_ary[scaler_cfg_pkg::AR_W-1];
		end
	end

	// Centring offsets
	assign hoff = (i_width - vid_w) >> 1;
	assign voff = (i_height - vid_h) >> 1;

	////////////////////
	// Window FSM
	////////////////////
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			state    <= ST_DECIDE;
			md_start <= 1'b0;
			o_win    <= '0;
		end else begin
			md_start <= 1'b0;
			case (state)
				ST_DECIDE: begin
					if (i_freescale || ax == '0 || ay == '0) begin
						wcalc <= disp_w;
						hcalc <= disp_h;
						state <= ST_CLAMP;
					end else if (literal) begin
						wcalc <= ax;
						hcalc <= ay;
						state <= ST_CLAMP;
					end else begin
						state <= ST_MUL_W;
					end
				end
				// w = height * ax / ay
				ST_MUL_W: begin
					md_mul1  <= disp_h;
					md_mul2  <= ax;
					md_div   <= ay;
					md_start <= 1'b1;
					state    <= ST_WAIT_W;
				end
				ST_WAIT_W: begin
					if (!md_start && !md_busy) begin
						wcalc <= md_res;
						state <= ST_MUL_H;
					end
				end
				// h = width * ay / ax
				ST_MUL_H: begin
					md_mul1  <= disp_w;
					md_mul2  <= ay;
					md_div   <= ax;
					md_start <= 1'b1;
					state    <= ST_WAIT_H;
				end
				ST_WAIT_H: begin
					if (!md_start && !md_busy) begin
						hcalc <= md_res;
						state <= ST_CLAMP;
					end
				end
				ST_CLAMP: begin
					vid_w <= (wcalc > disp_w) ? disp_w : wcalc;
					vid_h <= (hcalc > disp_h) ? disp_h : hcalc;
					state <= ST_CENTER;
				end
				ST_CENTER: begin
					o_win.hmin <= hoff;
					o_win.hmax <= hoff + vid_w - scaler_cfg_pkg::dim_t'(1);
					o_win.vmin <= voff;
					o_win.vmax <= voff + vid_h - scaler_cfg_pkg::dim_t'(1);
					state      <= ST_DECIDE;
				end
				default: state <= ST_DECIDE;
			endcase
		end
	end

endmodule

`default_nettype wire

/* src/video_cfg_top.sv */
////////////////////
// Video config top
// Host link, config registers and window calculator
////////////////////
`default_nettype none
`timescale 1ns/1ns

module video_cfg_top (
	input  logic                              clk_sys,
	input  logic                              resetd,
	input  logic                              i_io_en,
	input  logic                              i_io_clk,
	input  logic [scaler_cfg_pkg::IO_W-1:0]   i_io_din,
	input  scaler_cfg_pkg::ar_t               i_arx,
	input  scaler_cfg_pkg::ar_t               i_ary,
	output logic                              o_io_ack,
	output scaler_cfg_pkg::dim_t              o_hmin,
	output scaler_cfg_pkg::dim_t              o_hmax,
	output scaler_cfg_pkg::dim_t              o_vmin,
	output scaler_cfg_pkg::dim_t              o_vmax
);

	scaler_cfg_pkg::dim_t  width, height, hset, vset;
	logic                  freescale;
	scaler_cfg_pkg::ar_t   arc1x, arc1y, arc2x, arc2y;
	scaler_cfg_pkg::win_t  win;

	cmd_bus_if cmd_bus ();

	hps_cmd_link i_link (
		.clk_sys  (clk_sys),
		.resetd   (resetd),
		.i_io_en  (i_io_en),
		.i_io_clk (i_io_clk),
		.i_io_din (i_io_din),
		.o_io_ack (o_io_ack),
		.cmd      (cmd_bus.link_mp)
	);

	video_cfg_regs i_regs (
		.clk_sys     (clk_sys),
		.resetd      (resetd),
		.cmd         (cmd_bus.regs_mp),
		.o_width     (width),
		.o_height    (height),
		.o_hset      (hset),
		.o_vset      (vset),
		.o_freescale (freescale),
		.o_arc1x     (arc1x),
		.o_arc1y     (arc1y),
		.o_arc2x     (arc2x),
		.o_arc2y     (arc2y)
	);

	ar_window_calc i_calc (
		.clk_sys     (clk_sys),
		.resetd      (resetd),
		.i_width     (width),
		.i_height    (height),
		.i_hset      (hset),
		.i_vset      (vset),
		.i_freescale (freescale),
		.i_arx       (i_arx),
		.i_ary       (i_ary),
		.i_arc1x     (arc1x),
		.i_arc1y     (arc1y),
		.i_arc2x     (arc2x),
		.i_arc2y     (arc2y),
		.o_win       (win)
	);

	// Window out as plain ports
	assign o_hmin = win.hmin;
	assign o_hmax = win.hmax;
	assign o_vmin = win.vmin;
	assign o_vmax = win.vmax;

endmodule

`default_nettype wire

/* verification/video_cfg_props.sv */
////////////////////
// Video config properties
// Acknowledge timing and window ordering on the top level
////////////////////
`default_nettype none
`timescale 1ns/1ns

module video_cfg_props (
	input logic                  clk_sys,
	input logic                  resetd,
	input logic                  i_io_clk,
	input logic                  i_io_ack,
	input scaler_cfg_pkg::dim_t  i_hmin,
	input scaler_cfg_pkg::dim_t  i_hmax,
	input scaler_cfg_pkg::dim_t  i_vmin,
	input scaler_cfg_pkg::dim_t  i_vmax
);

	ack_in_reset: assert property (@(posedge clk_sys)
		resetd && $past(resetd) |-> !i_io_ack)
		else $error("acknowledge high during reset");

	// Two sync stages, sample register, ack register
	ack_latency: assert property (@(posedge clk_sys) disable iff (resetd)
		i_io_ack == $past(i_io_clk, 4))
		else $error("acknowledge does not follow the host clock by four cycles");

	hwin_order: assert property (@(posedge clk_sys) disable iff (resetd)
		i_hmin <= i_hmax)
		else $error("hmin above hmax");

	vwin_order: assert property (@(posedge clk_sys) disable iff (resetd)
		i_vmin <= i_vmax)
		else $error("vmin above vmax");

endmodule

`default_nettype wire

/* verification/window_checker.sv */
////////////////////
// Window checker
// Polls the DUT window against the expected one and
// follows the acknowledge against the delayed host clock
////////////////////
`default_nettype none
`timescale 1ns/1ns

module window_checker (
	input  logic                  clk_sys,
	input  logic                  resetd,
	input  logic                  i_io_clk,
	input  logic                  i_io_ack,
	input  scaler_cfg_pkg::dim_t  i_hmin,
	input  scaler_cfg_pkg::dim_t  i_hmax,
	input  scaler_cfg_pkg::dim_t  i_vmin,
	input  scaler_cfg_pkg::dim_t  i_vmax,
	input  logic                  i_start,
	input  scaler_cfg_pkg::win_t  i_expect,
	output logic                  o_done,
	output logic                  o_pass,
	output int                    o_errors
);

	localparam int POLL_MAX = 500;

	scaler_cfg_pkg::win_t  win_now;
	logic [3:0]            clk_hist;
	logic                  polling;
	int                    poll_cnt;
	int                    ack_errs;
	int                    win_errs;

	assign win_now  = {i_hmin, i_hmax, i_vmin, i_vmax};
	assign o_errors = ack_errs + win_errs;

	task automatic show_field(
		input string                 name,
		input scaler_cfg_pkg::dim_t  got,
		input scaler_cfg_pkg::dim_t  want
	);
		if (got !== want)
			$display("Mismatch at %0t: %s is %0d, expected %0d", $time, name, got, want);
	endtask

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			clk_hist <= '0;
			polling  <= 1'b0;
			poll_cnt <= 0;
			o_done   <= 1'b0;
			o_pass   <= 1'b0;
			ack_errs <= 0;
			win_errs <= 0;
		end else begin
			clk_hist <= {clk_hist[2:0], i_io_clk};
			o_done   <= 1'b0;
			// Ack is the host clock seen four edges ago
			if (i_io_ack !== clk_hist[3]) begin
				$display("Mismatch at %0t: o_io_ack is %b, expected %b",
					$time, i_io_ack, clk_hist[3]);
				ack_errs <= ack_errs + 1;
			end
			if (i_start) begin
				polling  <= 1'b1;
				poll_cnt <= 0;
			end else if (polling) begin
				if (win_now === i_expect) begin
					polling <= 1'b0;
					o_done  <= 1'b1;
					o_pass  <= 1'b1;
				end else if (poll_cnt >= POLL_MAX) begin
					show_field("hmin", i_hmin, i_expect.hmin);
					show_field("hmax", i_hmax, i_expect.hmax);
					show_field("vmin", i_vmin, i_expect.vmin);
					show_field("vmax", i_vmax, i_expect.vmax);
					win_errs <= win_errs + 1;
					polling  <= 1'b0;
					o_done   <= 1'b1;
					o_pass   <= 1'b0;
				end else begin
					poll_cnt <= poll_cnt + 1;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* verification/tb_video_cfg.sv */
////////////////////
// Video config testbench
// Replays the golden table over the host link
////////////////////
`default_nettype none
`timescale 1ns/1ns

module tb_video_cfg;

	localparam int    ACK_TIMEOUT  = 100;
	localparam int    DONE_TIMEOUT = 600;
	localparam string GOLDEN_FILE  = "verification/window_golden.txt";

	logic                  clk_sys;
	logic                  resetd;
	logic                  io_en;
	logic                  io_clk;
	logic [15:0]           io_din;
	scaler_cfg_pkg::ar_t   arx, ary;
	logic                  io_ack;
	scaler_cfg_pkg::dim_t  hmin, hmax, vmin, vmax;
	logic                  chk_start, chk_done, chk_pass;
	scaler_cfg_pkg::win_t  chk_expect;
	int                    chk_errors;
	int                    link_errors;
	int                    tests;
	int                    failed;

	video_cfg_top i_dut (
		.clk_sys  (clk_sys),
		.resetd   (resetd),
		.i_io_en  (io_en),
		.i_io_clk (io_clk),
		.i_io_din (io_din),
		.i_arx    (arx),
		.i_ary    (ary),
		.o_io_ack (io_ack),
		.o_hmin   (hmin),
		.o_hmax   (hmax),
		.o_vmin   (vmin),
		.o_vmax   (vmax)
	);

	window_checker i_checker (
		.clk_sys  (clk_sys),
		.resetd   (resetd),
		.i_io_clk (io_clk),
		.i_io_ack (io_ack),
		.i_hmin   (hmin),
		.i_hmax   (hmax),
		.i_vmin   (vmin),
		.i_vmax   (vmax),
		.i_start  (chk_start),
		.i_expect (chk_expect),
		.o_done   (chk_done),
		.o_pass   (chk_pass),
		.o_errors (chk_errors)
	);

	bind video_cfg_top video_cfg_props i_props (
		.clk_sys  (clk_sys),
		.resetd   (resetd),
		.i_io_clk (i_io_clk),
		.i_io_ack (o_io_ack),
		.i_hmin   (o_hmin),
		.i_hmax   (o_hmax),
		.i_vmin   (o_vmin),
		.i_vmax   (o_vmax)
	);

	always #4 clk_sys = ~clk_sys;

	////////////////////
	// Host link driver
	////////////////////
	task automatic wait_ack(input logic level);
		int n;
		n = 0;
		while (io_ack !== level && n < ACK_TIMEOUT) begin
			@(negedge clk_sys);
			n++;
		end
		if (io_ack !== level) begin
			$display("Host link got no acknowledge %b within %0d cycles at %0t",
				level, ACK_TIMEOUT, $time);
			link_errors++;
		end
	endtask

	// Data is set a cycle ahead of the strobe
	task automatic send_word(input logic [15:0] word);
		io_din = word;
		@(negedge clk_sys);
		io_clk = 1'b1;
		wait_ack(1'b1);
		io_clk = 1'b0;
		wait_ack(1'b0);
	endtask

	task automatic open_cmd(input logic [7:0] code);
		io_en = 1'b1;
		@(negedge clk_sys);
		send_word({8'h00, code});
	endtask

	// Long enough for the synchronised select to close the command
	task automatic close_cmd();
		io_en = 1'b0;
		repeat (3) @(negedge clk_sys);
	endtask

	task automatic send_single(input logic [7:0] code, input logic [15:0] word);
		open_cmd(code);
		send_word(word);
		close_cmd();
	endtask

	// Porch and sync words carry junk, only width and height count
	task automatic send_timing(input int width, input int height, input bit abort);
		open_cmd(scaler_cfg_pkg::CMD_TIMING);
		send_word(16'(width));
		if (!abort) begin
			for (int i = 1; i < 8; i++)
				send_word(i == 4 ? 16'(height) : 16'(i * 17));
		end
		close_cmd();
	endtask

	initial begin
		int    fd;
		int    n;
		int    wait_n;
		string line;
		string name;
		int    mode, width, height, hset, vset, fscale;
		int    ax, ay, c1x, c1y, c2x, c2y;
		int    e_hmin, e_hmax, e_vmin, e_vmax;

		clk_sys     = 1'b0;
		resetd      = 1'b1;
		io_en       = 1'b0;
		io_clk      = 1'b0;
		io_din      = '0;
		arx         = '0;
		ary         = '0;
		chk_start   = 1'b0;
		chk_expect  = '0;
		link_errors = 0;
		tests       = 0;
		failed      = 0;
		repeat (4) @(negedge clk_sys);
		resetd = 1'b0;

		fd = $fopen(GOLDEN_FILE, "r");
		if (fd == 0) begin
			$display("Could not open the golden file %s", GOLDEN_FILE);
			link_errors++;
		end else begin
			while ($fgets(line, fd) != 0) begin
				if (line.len() < 2 || line.getc(0) == "#")
					continue;
				n = $sscanf(line, "%s %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
					name, mode, width, height, hset, vset, fscale, ax, ay,
					c1x, c1y, c2x, c2y, e_hmin, e_hmax, e_vmin, e_vmax);
				if (n != 17) begin
					$display("Golden line could not be parsed: %s", line);
					link_errors++;
					continue;
				end

				// Mode 2 leaves the registers as they are
				if (mode != 2) begin
					send_timing(width, height, mode == 1);
					send_single(scaler_cfg_pkg::CMD_VSET, 16'(vset));
					send_single(scaler_cfg_pkg::CMD_HSET_FREE,
						{fscale[0], 3'b000, hset[11:0]});
					open_cmd(scaler_cfg_pkg::CMD_AR_PRESET);
					send_word(16'(c1x));
					send_word(16'(c1y));
					send_word(16'(c2x));
					send_word(16'(c2y));
					close_cmd();
				end
				arx        = 13'(ax);
				ary        = 13'(ay);
				chk_expect = {12'(e_hmin), 12'(e_hmax), 12'(e_vmin), 12'(e_vmax)};
				chk_start  = 1'b1;
				@(negedge clk_sys);
				chk_start = 1'b0;

				wait_n = 0;
				while (!chk_done && wait_n < DONE_TIMEOUT) begin
					@(negedge clk_sys);
					wait_n++;
				end
				tests++;
				if (chk_done && chk_pass) begin
					$display("Test %s passed", name);
				end else begin
					failed++;
					if (!chk_done)
						$display("Test %s got no verdict from the checker", name);
					else
						$display("Test %s failed", name);
				end
			end
			$fclose(fd);
		end

		$display("Summary: %0d tests, %0d failed, %0d checker errors, %0d link errors",
			tests, failed, chk_errors, link_errors);
		if (tests > 0 && failed == 0 && chk_errors == 0 && link_errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

/* verification/window_golden.txt */
# name mode width height hset vset free arx ary arc1x arc1y arc2x arc2y hmin hmax vmin vmax
# mode 0 sends every command, 1 drops select after the width word, 2 sends nothing
reset_defaults 2 1920 1080 0 0 0 0 0 0 0 0 0 0 1919 0 1079
aspect_4_3 0 1920 1080 0 0 0 4 3 0 0 0 0 240 1679 0 1079
aspect_4_3_720p 0 1280 720 0 0 0 4 3 0 0 0 0 160 1119 0 719
aspect_21_9_720p 0 1280 720 0 0 0 21 9 0 0 0 0 0 1279 86 633
hset_vset_limits 0 1920 1080 1600 900 0 4 3 0 0 0 0 360 1559 90 989
free_scale 0 1920 1080 1600 900 1 4 3 0 0 0 0 160 1759 90 989
preset_1 0 1920 1080 0 0 0 1 0 5 4 3 2 285 1634 0 1079
preset_2 0 1920 1080 0 0 0 2 0 5 4 3 2 150 1769 0 1079
literal_size 0 1920 1080 0 0 0 1 0 4896 4696 3 2 560 1359 240 839
literal_clamp 0 1920 1080 0 720 0 2 0 4896 4696 6096 5296 0 1919 180 899
deselect_abort 1 1280 720 0 0 0 4 3 4896 4696 6096 5296 0 1279 60 1019
unknown_preset 0 1920 1080 0 0 0 3 0 5 4 3 2 0 1919 0 1079

/* all.f */
src/scaler_cfg_pkg.sv
src/cmd_bus_if.sv
src/hps_cmd_link.sv
src/video_cfg_regs.sv
src/seq_muldiv.sv
src/ar_window_calc.sv
src/video_cfg_top.sv
verification/video_cfg_props.sv
verification/window_checker.sv
verification/tb_video_cfg.sv

/* Makefile */
# Verilator build and run for the video config testbench

VERILATOR ?= verilator
TOP       ?= tb_video_cfg
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing
FAIL_MSG  := ERRORS FOUND
PASS_MSG  := NO ERRORS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation did not complete"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
